/* Makefile */
VERILATOR ?= verilator
TOP       ?= tb_int_core
LOG       ?= sim.log
FLIST     ?= project.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

# Build, run, then decide on the log
sim:
	$(VERILATOR) --binary --timing --assert -f $(FLIST) --top-module $(TOP) \
		--Mdir $(OBJ_DIR) -o V$(TOP)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_ref_model.svh */
////////////////////
// Reference model of the retire stream for RV32I. Memory and load data are not modelled
////////////////////

// One expected retire
typedef struct {
  uop_kind_t kind;
  reg_addr_t rd;
  logic      we;
  word_t     data;   // Result or effective address
  word_t     sdata;  // Store data
  lsu_ctrl_t lsu;
} retire_rec_t;

word_t shadow [32] = '{default: '0};  // Registers in program order

function automatic word_t sext12(input logic [11:0] v);
  return {{20{v[11]}}, v};
endfunction

////////////////////
// Encoders
////////////////////
function automatic word_t enc_r(input logic [2:0] f3, input logic alt,
                                input int rd, input int rs1, input int rs2);
  return {alt ? FUNCT7_ALT : FUNCT7_BASE, 5'(rs2), 5'(rs1), f3, 5'(rd), OPC_OP};
endfunction

function automatic word_t enc_i(input logic [6:0] opc, input logic [2:0] f3,
                                input int rd, input int rs1, input logic [11:0] imm);
  return {imm, 5'(rs1), f3, 5'(rd), opc};
endfunction

function automatic word_t enc_s(input logic [2:0] f3, input int rs1, input int rs2,
                                input logic [11:0] imm);
  return {imm[11:5], 5'(rs2), 5'(rs1), f3, imm[4:0], OPC_STORE};
endfunction

function automatic word_t enc_u(input logic [6:0] opc, input int rd, input logic [19:0] imm);
  return {imm, 5'(rd), opc};
endfunction

// Spec behavior of the ten functions
function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
  case (f3)
    FUNCT3_ADD:  return alt ? a - b : a + b;
    FUNCT3_SLL:  return a << b[4:0];
    FUNCT3_SLT:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    FUNCT3_SLTU: return (a < b) ? 32'd1 : 32'd0;
    FUNCT3_XOR:  return a ^ b;
    FUNCT3_SR:   return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
    FUNCT3_OR:   return a | b;
    default:     return a & b;
  endcase
endfunction

// Expected retire of one instruction, shadow updated as it would commit
function automatic retire_rec_t predict(input word_t ins);
  retire_rec_t r;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic        alt;
  word_t       a;
  word_t       b;
  f3      = ins[14:12];
  f7      = ins[31:25];
  a       = shadow[ins[19:15]];
  b       = shadow[ins[24:20]];
  r.kind  = UOP_ILLEGAL;  // Anything without a PC
  r.rd    = ins[11:7];
  r.we    = 1'b0;
  r.data  = '0;
  r.sdata = '0;
  r.lsu   = {1'b0, f3};
  case (ins[6:0])
    OPC_OP: begin
      if ((f7 == FUNCT7_BASE) ||
          ((f7 == FUNCT7_ALT) && ((f3 == FUNCT3_ADD) || (f3 == FUNCT3_SR)))) begin
        r.kind = UOP_ALU;
        r.we   = 1'b1;
        r.data = alu_model(f3, ins[30], a, b);
      end
    end
    OPC_OPIMM: begin
      alt = (f3 == FUNCT3_SR) && ins[30];  // SRAI only
      if (((f3 != FUNCT3_SLL) && (f3 != FUNCT3_SR)) || (f7 == FUNCT7_BASE) ||
          (alt && (f7 == FUNCT7_ALT))) begin
        r.kind = UOP_ALU;
        r.we   = 1'b1;
        r.data = alu_model(f3, alt, a, sext12(ins[31:20]));
      end
    end
    OPC_LUI: begin
      r.kind = UOP_ALU;
      r.we   = 1'b1;
      r.data = {ins[31:12], 12'b0};
    end
    OPC_LOAD: begin
      r.kind = UOP_MEM;  // No write, data never returns
      r.data = a + sext12(ins[31:20]);
    end
    OPC_STORE: begin
      r.kind  = UOP_MEM;
      r.data  = a + sext12({ins[31:25], ins[11:7]});
      r.sdata = b;
      r.lsu   = {1'b1, f3};
    end
    OPC_MISCMEM: r.kind = UOP_NOP;
    default: ;
  endcase
  if (r.we && (r.rd != '0)) begin
    shadow[r.rd] = r.data;
  end
  return r;
endfunction

/* bench/tb_int_core.sv */
`timescale 1ns/100ps
////////////////////
// Directed tests on the retire port. Loads retire as requests only
////////////////////
module tb_int_core;
  import rv_isa_pkg::*;
  import core_uop_pkg::*;

  localparam int NUM_REGS     = 32;
  localparam int RESET_CYCLES = 8;
  localparam int STREAM_LEN   = 200;
  localparam int SEED         = 75949;
  localparam int INSTR_BUDGET = 1000;  // All tests, stall cycles and fill
  localparam int MAX_CYCLES   = 4 * INSTR_BUDGET;

  logic                    clk_i = 1'b0;
  logic                    rstn_i;
  logic                    instr_valid_i;
  word_t                   instr_i;
  logic                    instr_ready_o;
  logic                    retire_valid_o;
  logic                    retire_ready_i;
  uop_kind_t               retire_kind_o;
  reg_addr_t               retire_rd_o;
  logic                    retire_we_o;
  word_t                   retire_data_o;
  word_t                   retire_store_data_o;
  lsu_ctrl_t               retire_lsu_ctrl_o;

  `include "tb_ref_model.svh"

  retire_rec_t exp_q [$];   // Expected retires in order
  word_t       feed_q [$];  // Encoded instructions not yet sent
  string       cur_test;
  int          test_errs = 0;
  int          errors    = 0;
  int          checks    = 0;
  int          cycles    = 0;

  int_core_top #(.NUM_REGS(NUM_REGS)) dut (.*);

  always #10 clk_i = ~clk_i;  // 20 ns

  // Hang guard
  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MAX_CYCLES) begin
      $display("Timeout: run did not finish within %0d cycles", MAX_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic check_val(input string what, input word_t exp, input word_t act);
    checks++;
    assert (act === exp) else begin
      $display("Mismatch %s %s: expected %h, actual %h", cur_test, what, exp, act);
      test_errs++;
    end
  endtask

  // Fields that the kind defines
  task automatic check_retire(input retire_rec_t r);
    check_val("kind", 32'(r.kind), 32'(retire_kind_o));
    check_val("we", 32'(r.we), 32'(retire_we_o));
    if ((r.kind == UOP_ALU) || (r.kind == UOP_MEM)) begin
      check_val("data", r.data, retire_data_o);
    end
    if ((r.kind == UOP_ALU) || ((r.kind == UOP_MEM) && !r.lsu[3])) begin
      check_val("rd", 32'(r.rd), 32'(retire_rd_o));
    end
    if (r.kind == UOP_MEM) begin
      check_val("lsu ctrl", 32'(r.lsu), 32'(retire_lsu_ctrl_o));
    end
    if ((r.kind == UOP_MEM) && r.lsu[3]) begin
      check_val("store data", r.sdata, retire_store_data_o);
    end
  endtask

  task automatic issue(input word_t ins);
    exp_q.push_back(predict(ins));
    feed_q.push_back(ins);
  endtask

  task automatic load_const(input int rd, input word_t v);
    word_t hi;
    hi = (v + 32'h800) >> 12;  // Rounded for the signed low part
    issue(enc_u(OPC_LUI, rd, hi[19:0]));
    issue(enc_i(OPC_OPIMM, FUNCT3_ADD, rd, rd, v[11:0]));
  endtask

  task automatic feed();
    while (feed_q.size() > 0) begin
      instr_valid_i <= 1'b1;
      instr_i       <= feed_q.pop_front();
      @(posedge clk_i);
      while (!instr_ready_o) @(posedge clk_i);  // Held until accepted
    end
    instr_valid_i <= 1'b0;
  endtask

  task automatic drain(input logic stall);
    retire_rec_t r;
    while (exp_q.size() > 0) begin
      @(posedge clk_i);
      if (retire_valid_o && retire_ready_i) begin
        r = exp_q.pop_front();
        check_retire(r);
      end
      retire_ready_i <= stall ? 1'($urandom_range(1)) : 1'b1;
    end
    retire_ready_i <= 1'b1;
  endtask

  task automatic run_test(input string name, input logic stall);
    int n;
    n        = exp_q.size();
    cur_test = name;
    fork
      feed();
      drain(stall);
    join
    @(posedge clk_i);
    assert (!retire_valid_o) else begin
      $display("Test %s: extra retire after the expected stream ended", name);
      test_errs++;
    end
    $display("test %-8s %0d instructions, %0d errors", name, n, test_errs);
    errors   += test_errs;
    test_errs = 0;
  endtask

  ////////////////////
  // Tests
  ////////////////////
  task automatic test_reset();
    cur_test = "reset";
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clk_i);
      if (i > 0) check_val("valid in reset", 32'h0, 32'(retire_valid_o));
    end
    rstn_i <= 1'b1;
    repeat (2) begin
      @(posedge clk_i);
      check_val("valid after reset", 32'h0, 32'(retire_valid_o));
    end
    issue(enc_i(OPC_OPIMM, FUNCT3_ADD, 1, 0, 12'h8A5));  // Negative immediate
    run_test("reset", 1'b0);
  endtask

  task automatic test_chain();
    issue(enc_u(OPC_LUI, 5, 20'h87654));
    issue(enc_i(OPC_OPIMM, FUNCT3_ADD, 5, 5, 12'h321));  // From execute
    issue(enc_r(FUNCT3_ADD, 1'b0, 6, 5, 5));
    issue(enc_r(FUNCT3_ADD, 1'b1, 7, 6, 5));             // SUB, rs2 from writeback
    issue(enc_i(OPC_OPIMM, FUNCT3_ADD, 0, 7, 12'h055));  // Write to x0
    issue(enc_r(FUNCT3_OR, 1'b0, 8, 0, 7));              // x0 zero, x7 from writeback
    issue(enc_r(FUNCT3_XOR, 1'b0, 9, 5, 1));             // Register file
    run_test("chain", 1'b0);
  endtask

  task automatic test_alu();
    word_t      a;
    word_t      b;
    logic [11:0] imm;
    logic [4:0]  sh;
    for (int r = 0; r < 3; r++) begin
      a   = (r == 1) ? 32'h8000_0000 : $urandom();  // SLT against SLTU
      b   = (r == 1) ? 32'h1 : $urandom();
      imm = (r == 0) ? 12'hFFB : (r == 1) ? 12'hFFF : 12'($urandom());
      sh  = (r == 0) ? 5'd0 : (r == 1) ? 5'd31 : 5'($urandom_range(31));
      load_const(1, a);
      load_const(2, b);
      for (int f = 0; f < 8; f++) begin
        issue(enc_r(3'(f), 1'b0, 3 + f, 1, 2));
      end
      issue(enc_r(FUNCT3_ADD, 1'b1, 11, 1, 2));  // SUB
      issue(enc_r(FUNCT3_SR, 1'b1, 12, 1, 2));   // SRA
      for (int f = 0; f < 8; f++) begin
        if ((f == 1) || (f == 5)) issue(enc_i(OPC_OPIMM, 3'(f), 13 + f, 1, {7'h00, sh}));
        else issue(enc_i(OPC_OPIMM, 3'(f), 13 + f, 1, imm));
      end
      issue(enc_i(OPC_OPIMM, FUNCT3_SR, 21, 1, {7'h20, sh}));  // SRAI
    end
    run_test("alu", 1'b0);
  endtask

  task automatic test_mem();
    load_const(4, 32'h0001_2340);
    load_const(5, $urandom());
    issue(enc_i(OPC_LOAD, 3'b010, 6, 4, 12'hFF8));  // LW x6, -8(x4)
    issue(enc_i(OPC_LOAD, 3'b100, 7, 4, 12'h7FF));  // LBU
    issue(enc_s(3'b010, 4, 5, 12'h014));            // SW x5, 20(x4)
    issue(enc_s(3'b000, 4, 5, 12'h800));            // SB, lowest offset
    issue(enc_r(FUNCT3_ADD, 1'b0, 8, 6, 0));        // x6 untouched by the load
    run_test("mem", 1'b0);
  endtask

  task automatic test_illegal();
    load_const(7, $urandom());
    issue(enc_u(OPC_AUIPC, 7, 20'h12345));
    issue(enc_i(OPC_BRANCH, 3'b000, 7, 1, 12'h010));
    issue(enc_u(OPC_JAL, 7, 20'h00100));
    issue(enc_i(OPC_JALR, 3'b000, 7, 1, 12'h004));
    issue(32'h0000_0073);                              // ECALL
    issue(enc_i(7'b0001011, 3'b000, 7, 1, 12'h001));   // Custom opcode
    issue(enc_r(FUNCT3_ADD, 1'b1, 7, 1, 2) | 32'h0200_0000);  // funct7 of 0x21
    issue(enc_i(OPC_MISCMEM, 3'b000, 0, 0, 12'h0FF));  // FENCE
    issue(enc_r(FUNCT3_ADD, 1'b0, 9, 7, 0));           // Old x7
    run_test("illegal", 1'b0);
  endtask

  // Mix over x0..x7 for dense dependencies
  function automatic word_t rand_instr();
    logic [2:0] f3;
    logic [4:0] sh;
    logic       alt;
    int         rd;
    int         rs1;
    int         rs2;
    f3  = 3'($urandom_range(7));
    sh  = 5'($urandom_range(31));
    alt = ((f3 == FUNCT3_ADD) || (f3 == FUNCT3_SR)) && ($urandom_range(1) == 1);
    rd  = $urandom_range(7);
    rs1 = $urandom_range(7);
    rs2 = $urandom_range(7);
    case ($urandom_range(9))
      0, 1, 2: return enc_r(f3, alt, rd, rs1, rs2);
      3, 4:    return enc_i(OPC_OPIMM, f3, rd, rs1, 12'($urandom()));
      5:       return enc_i(OPC_OPIMM, FUNCT3_SR, rd, rs1, {1'b0, f3[2], 5'b0, sh});
      6:       return enc_u(OPC_LUI, rd, 20'($urandom()));
      7:       return enc_i(OPC_LOAD, f3, rd, rs1, 12'($urandom()));
      8:       return enc_s(f3, rs1, rs2, 12'($urandom()));
      default: return enc_u(OPC_JAL, rd, 20'($urandom()));  // Illegal here
    endcase
  endfunction

  task automatic test_stream();
    for (int i = 0; i < STREAM_LEN; i++) begin
      issue(rand_instr());
    end
    run_test("stream", 1'b1);  // Random retire stalls
  endtask

  initial begin
    rstn_i         = 1'b0;
    instr_valid_i  = 1'b0;
    instr_i        = '0;
    retire_ready_i = 1'b1;
    void'($urandom(SEED));
    test_reset();
    test_chain();
    test_alu();
    test_mem();
    test_illegal();
    test_stream();
    $display("total: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

/* design/core_uop_pkg.sv */
////////////////////
// Micro-op fields shared by the pipeline stages
////////////////////
package core_uop_pkg;

  // Instruction bit 30 on top of funct3
  typedef enum logic [3:0] {
    ALU_ADD  = 4'b0000,
    ALU_SUB  = 4'b1000,
    ALU_SLL  = 4'b0001,
    ALU_SLT  = 4'b0010,
    ALU_SLTU = 4'b0011,
    ALU_XOR  = 4'b0100,
    ALU_SRL  = 4'b0101,
    ALU_SRA  = 4'b1101,
    ALU_OR   = 4'b0110,
    ALU_AND  = 4'b0111
  } alu_op_t;

  // Store flag in bit 3, funct3 below it
  typedef logic [3:0] lsu_ctrl_t;

  // What the retire port reports
  typedef enum logic [1:0] {
    UOP_ALU     = 2'd0,
    UOP_MEM     = 2'd1,  // Load or store request
    UOP_NOP     = 2'd2,
    UOP_ILLEGAL = 2'd3
  } uop_kind_t;

endpackage

/* design/decode_stage.sv */
`timescale 1ns/100ps
////////////////////
// One micro-op register. No PC here, so control flow and SYSTEM decode as illegal
////////////////////
module decode_stage #(
  parameter int NUM_REGS = 32  // 32 for RV32I, 16 for RV32E
) (
  input  logic                    clk_i,
  input  logic                    rstn_i,
  input  logic                    instr_valid_i,
  input  rv_isa_pkg::word_t       instr_i,
  output logic                    instr_ready_o,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output core_uop_pkg::uop_kind_t out_kind_o,
  output core_uop_pkg::alu_op_t   out_alu_op_o,
  output logic                    out_use_imm_o,
  output rv_isa_pkg::reg_addr_t   out_rs1_o,
  output rv_isa_pkg::reg_addr_t   out_rs2_o,
  output rv_isa_pkg::reg_addr_t   out_rd_o,
  output logic                    out_we_o,
  output core_uop_pkg::lsu_ctrl_t out_lsu_ctrl_o,
  output rv_isa_pkg::word_t       out_imm_o
);
  import rv_isa_pkg::*;
  import core_uop_pkg::*;

  logic [OPCODE_W-1:0] opcode;
  logic [FUNCT3_W-1:0] funct3;
  logic [FUNCT7_W-1:0] funct7;
  word_t               imm_i;
  word_t               imm_s;
  word_t               imm_u;

  // Next micro-op
  uop_kind_t kind_d;
  alu_op_t   alu_op_d;
  logic      use_imm_d;
  logic      we_d;
  lsu_ctrl_t lsu_d;
  word_t     imm_d;
  logic      f7_ok;    // funct7 legal for the function
  logic      use_rs1;
  logic      use_rs2;
  logic      use_rd;
  logic      bad_reg;  // Index beyond NUM_REGS

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];

  // Sign-extended immediates
  assign imm_i = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_u = {instr_i[31:12], 12'b0};

  always_comb begin
    kind_d    = UOP_ILLEGAL;
    alu_op_d  = ALU_ADD;   // Address adds for LOAD and STORE
    use_imm_d = 1'b1;
    we_d      = 1'b0;
    lsu_d     = {1'b0, funct3};
    imm_d     = imm_i;
    f7_ok     = 1'b1;
    use_rs1   = 1'b0;
    use_rs2   = 1'b0;
    use_rd    = 1'b0;
    case (opcode)
      OPC_OPIMM: begin
        kind_d   = UOP_ALU;
        alu_op_d = alu_op_t'({(funct3 == FUNCT3_SR) & instr_i[30], funct3});  // Bit 30 only for SRAI
        we_d     = 1'b1;
        use_rs1  = 1'b1;
        use_rd   = 1'b1;
        if (funct3 == FUNCT3_SLL) begin
          f7_ok = (funct7 == FUNCT7_BASE);
        end else if (funct3 == FUNCT3_SR) begin
          f7_ok = (funct7 == FUNCT7_BASE) || (funct7 == FUNCT7_ALT);
        end
      end
      OPC_OP: begin
        kind_d    = UOP_ALU;
        alu_op_d  = alu_op_t'({instr_i[30], funct3});
        use_imm_d = 1'b0;
        we_d      = 1'b1;
        use_rs1   = 1'b1;
        use_rs2   = 1'b1;
        use_rd    = 1'b1;
        // ALT only for SUB and SRA
        f7_ok = (funct7 == FUNCT7_BASE) ||
                ((funct7 == FUNCT7_ALT) && ((funct3 == FUNCT3_ADD) || (funct3 == FUNCT3_SR)));
      end
      OPC_LUI: begin
        kind_d = UOP_ALU;  // x0 + U immediate
        imm_d  = imm_u;
        we_d   = 1'b1;
        use_rd = 1'b1;
      end
      OPC_LOAD: begin
        kind_d  = UOP_MEM;  // rd kept, no write without load data
        use_rs1 = 1'b1;
        use_rd  = 1'b1;
      end
      OPC_STORE: begin
        kind_d  = UOP_MEM;
        imm_d   = imm_s;
        lsu_d   = {1'b1, funct3};
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      OPC_MISCMEM: kind_d = UOP_NOP;
      default: kind_d = UOP_ILLEGAL;  // AUIPC, branches, jumps, SYSTEM, unknown
    endcase

    bad_reg = (use_rs1 && int'(instr_i[19:15]) >= NUM_REGS) ||
              (use_rs2 && int'(instr_i[24:20]) >= NUM_REGS) ||
              (use_rd  && int'(instr_i[11:7])  >= NUM_REGS);
    if (!f7_ok || bad_reg) begin
      kind_d = UOP_ILLEGAL;
    end
    if (kind_d == UOP_ILLEGAL) begin
      alu_op_d = ALU_ADD;
      we_d     = 1'b0;
    end
  end

  ////////////////////
  // Pipeline register
  ////////////////////
  assign instr_ready_o = !out_valid_o || out_ready_i;  // Empty or draining

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      out_valid_o <= 1'b0;
    end else if (instr_ready_o) begin
      out_valid_o <= instr_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (instr_valid_i && instr_ready_o) begin
      out_kind_o     <= kind_d;
      out_alu_op_o   <= alu_op_d;
      out_use_imm_o  <= use_imm_d;
      out_rs1_o      <= use_rs1 ? instr_i[19:15] : '0;  // Unused fields read x0
      out_rs2_o      <= use_rs2 ? instr_i[24:20] : '0;
      out_rd_o       <= use_rd ? instr_i[11:7] : '0;
      out_we_o       <= we_d;
      out_lsu_ctrl_o <= lsu_d;
      out_imm_o      <= imm_d;
    end
  end

  // Illegal micro-ops never reach the register file
  a_illegal_no_we: assert property (@(posedge clk_i) disable iff (!rstn_i)
    out_valid_o && (out_kind_o == UOP_ILLEGAL) |-> !out_we_o);

endmodule

/* design/execute_stage.sv */
`timescale 1ns/100ps
////////////////////
// Forwards from its own register, then writeback, then the register file
////////////////////
module execute_stage (
  input  logic                    clk_i,
  input  logic                    rstn_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  input  core_uop_pkg::uop_kind_t in_kind_i,
  input  core_uop_pkg::alu_op_t   in_alu_op_i,
  input  logic                    in_use_imm_i,
  input  rv_isa_pkg::reg_addr_t   in_rs1_i,
  input  rv_isa_pkg::reg_addr_t   in_rs2_i,
  input  rv_isa_pkg::reg_addr_t   in_rd_i,
  input  logic                    in_we_i,
  input  core_uop_pkg::lsu_ctrl_t in_lsu_ctrl_i,
  input  rv_isa_pkg::word_t       in_imm_i,
  output rv_isa_pkg::reg_addr_t   rf_raddr_a_o,
  output rv_isa_pkg::reg_addr_t   rf_raddr_b_o,
  input  rv_isa_pkg::word_t       rf_rdata_a_i,
  input  rv_isa_pkg::word_t       rf_rdata_b_i,
  input  logic                    wb_valid_i,
  input  logic                    wb_we_i,
  input  rv_isa_pkg::reg_addr_t   wb_rd_i,
  input  rv_isa_pkg::word_t       wb_data_i,
  output logic                    out_valid_o,
  input  logic                    out_ready_i,
  output core_uop_pkg::uop_kind_t out_kind_o,
  output rv_isa_pkg::reg_addr_t   out_rd_o,
  output logic                    out_we_o,
  output rv_isa_pkg::word_t       out_data_o,
  output rv_isa_pkg::word_t       out_store_data_o,
  output core_uop_pkg::lsu_ctrl_t out_lsu_ctrl_o
);
  import rv_isa_pkg::*;
  import core_uop_pkg::*;

  word_t rs1_val;
  word_t rs2_val;  // Also the store data
  word_t op_b;
  word_t alu_res;

  // Newest older result for one source
  function automatic word_t fwd(input reg_addr_t rs, input word_t rf_data);
    word_t val;
    val = rf_data;
    if (rs != '0) begin  // x0 stays zero
      if (out_valid_o && out_we_o && (out_rd_o == rs)) begin
        val = out_data_o;
      end else if (wb_valid_i && wb_we_i && (wb_rd_i == rs)) begin
        val = wb_data_i;
      end
    end
    return val;
  endfunction

  assign rf_raddr_a_o = in_rs1_i;
  assign rf_raddr_b_o = in_rs2_i;

  always_comb begin
    rs1_val = fwd(in_rs1_i, rf_rdata_a_i);
    rs2_val = fwd(in_rs2_i, rf_rdata_b_i);
    op_b    = in_use_imm_i ? in_imm_i : rs2_val;
  end

  ////////////////////
  // ALU
  ////////////////////
  always_comb begin
    case (in_alu_op_i)
      ALU_SUB:  alu_res = rs1_val - op_b;
      ALU_SLL:  alu_res = rs1_val << op_b[4:0];
      ALU_SLT:  alu_res = {{(XLEN-1){1'b0}}, $signed(rs1_val) < $signed(op_b)};
      ALU_SLTU: alu_res = {{(XLEN-1){1'b0}}, rs1_val < op_b};
      ALU_XOR:  alu_res = rs1_val ^ op_b;
      ALU_SRL:  alu_res = rs1_val >> op_b[4:0];
      ALU_SRA:  alu_res = word_t'($signed(rs1_val) >>> op_b[4:0]);
      ALU_OR:   alu_res = rs1_val | op_b;
      ALU_AND:  alu_res = rs1_val & op_b;
      default:  alu_res = rs1_val + op_b;  // ADD, LUI and addresses
    endcase
  end

  assign in_ready_o = !out_valid_o || out_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      out_valid_o <= 1'b0;
    end else if (in_ready_o) begin
      out_valid_o <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      out_kind_o       <= in_kind_i;
      out_rd_o         <= in_rd_i;
      out_we_o         <= in_we_i;
      out_data_o       <= alu_res;
      out_store_data_o <= rs2_val;
      out_lsu_ctrl_o   <= in_lsu_ctrl_i;
    end
  end

  // Held result survives a stall
  a_out_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_kind_o) &&
      $stable(out_rd_o) && $stable(out_we_o) && $stable(out_data_o) &&
      $stable(out_store_data_o) && $stable(out_lsu_ctrl_o));

endmodule

/* design/int_core_top.sv */
`timescale 1ns/100ps
////////////////////
// Three stages, no PC. NUM_REGS of 32 gives RV32I, 16 gives RV32E
////////////////////
module int_core_top #(
  parameter int NUM_REGS = 32
) (
  input  logic                    clk_i,
  input  logic                    rstn_i,
  input  logic                    instr_valid_i,
  input  rv_isa_pkg::word_t       instr_i,
  output logic                    instr_ready_o,
  output logic                    retire_valid_o,
  input  logic                    retire_ready_i,
  output core_uop_pkg::uop_kind_t retire_kind_o,
  output rv_isa_pkg::reg_addr_t   retire_rd_o,
  output logic                    retire_we_o,
  output rv_isa_pkg::word_t       retire_data_o,
  output rv_isa_pkg::word_t       retire_store_data_o,
  output core_uop_pkg::lsu_ctrl_t retire_lsu_ctrl_o
);
  import rv_isa_pkg::*;
  import core_uop_pkg::*;

  // Decode to execute
  logic      de_valid;
  logic      de_ready;
  uop_kind_t de_kind;
  alu_op_t   de_alu_op;
  logic      de_use_imm;
  reg_addr_t de_rs1;
  reg_addr_t de_rs2;
  reg_addr_t de_rd;
  logic      de_we;
  lsu_ctrl_t de_lsu;
  word_t     de_imm;

  // Execute to writeback
  logic      ew_valid;
  logic      ew_ready;
  uop_kind_t ew_kind;
  reg_addr_t ew_rd;
  logic      ew_we;
  word_t     ew_data;
  word_t     ew_sdata;
  lsu_ctrl_t ew_lsu;

  // Register file and forwarding
  reg_addr_t rf_raddr_a;
  reg_addr_t rf_raddr_b;
  word_t     rf_rdata_a;
  word_t     rf_rdata_b;
  logic      rf_we;
  reg_addr_t rf_waddr;
  word_t     rf_wdata;
  logic      wb_valid;
  logic      wb_we;
  reg_addr_t wb_rd;
  word_t     wb_data;

  decode_stage #(.NUM_REGS(NUM_REGS)) u_decode (
    .clk_i, .rstn_i, .instr_valid_i, .instr_i, .instr_ready_o,
    .out_valid_o(de_valid), .out_ready_i(de_ready), .out_kind_o(de_kind),
    .out_alu_op_o(de_alu_op), .out_use_imm_o(de_use_imm), .out_rs1_o(de_rs1),
    .out_rs2_o(de_rs2), .out_rd_o(de_rd), .out_we_o(de_we),
    .out_lsu_ctrl_o(de_lsu), .out_imm_o(de_imm)
  );

  execute_stage u_execute (
    .clk_i, .rstn_i,
    .in_valid_i(de_valid), .in_ready_o(de_ready), .in_kind_i(de_kind),
    .in_alu_op_i(de_alu_op), .in_use_imm_i(de_use_imm), .in_rs1_i(de_rs1),
    .in_rs2_i(de_rs2), .in_rd_i(de_rd), .in_we_i(de_we),
    .in_lsu_ctrl_i(de_lsu), .in_imm_i(de_imm),
    .rf_raddr_a_o(rf_raddr_a), .rf_raddr_b_o(rf_raddr_b),
    .rf_rdata_a_i(rf_rdata_a), .rf_rdata_b_i(rf_rdata_b),
    .wb_valid_i(wb_valid), .wb_we_i(wb_we), .wb_rd_i(wb_rd), .wb_data_i(wb_data),
    .out_valid_o(ew_valid), .out_ready_i(ew_ready), .out_kind_o(ew_kind),
    .out_rd_o(ew_rd), .out_we_o(ew_we), .out_data_o(ew_data),
    .out_store_data_o(ew_sdata), .out_lsu_ctrl_o(ew_lsu)
  );

  writeback_stage u_writeback (
    .clk_i, .rstn_i,
    .in_valid_i(ew_valid), .in_ready_o(ew_ready), .in_kind_i(ew_kind),
    .in_rd_i(ew_rd), .in_we_i(ew_we), .in_data_i(ew_data),
    .in_store_data_i(ew_sdata), .in_lsu_ctrl_i(ew_lsu),
    .retire_valid_o, .retire_ready_i, .retire_kind_o, .retire_rd_o,
    .retire_we_o, .retire_data_o, .retire_store_data_o, .retire_lsu_ctrl_o,
    .rf_we_o(rf_we), .rf_waddr_o(rf_waddr), .rf_wdata_o(rf_wdata),
    .wb_valid_o(wb_valid), .wb_we_o(wb_we), .wb_rd_o(wb_rd), .wb_data_o(wb_data)
  );

  reg_file #(.NUM_REGS(NUM_REGS)) u_reg_file (
    .clk_i, .rstn_i,
    .raddr_a_i(rf_raddr_a), .raddr_b_i(rf_raddr_b),
    .rdata_a_o(rf_rdata_a), .rdata_b_o(rf_rdata_b),
    .we_i(rf_we), .waddr_i(rf_waddr), .wdata_i(rf_wdata)
  );

endmodule

/* design/reg_file.sv */
`timescale 1ns/100ps
////////////////////
// Reads are combinational. Out-of-range indexes read zero
////////////////////
module reg_file #(
  parameter int NUM_REGS = 32
) (
  input  logic                  clk_i,
  input  logic                  rstn_i,
  input  rv_isa_pkg::reg_addr_t raddr_a_i,
  input  rv_isa_pkg::reg_addr_t raddr_b_i,
  output rv_isa_pkg::word_t     rdata_a_o,
  output rv_isa_pkg::word_t     rdata_b_o,
  input  logic                  we_i,
  input  rv_isa_pkg::reg_addr_t waddr_i,
  input  rv_isa_pkg::word_t     wdata_i
);
  import rv_isa_pkg::*;

  localparam int AW = $clog2(NUM_REGS);  // Storage index width

  word_t regs_q [NUM_REGS];

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && (waddr_i != '0) && (int'(waddr_i) < NUM_REGS)) begin
      regs_q[waddr_i[AW-1:0]] <= wdata_i;  // x0 never written
    end
  end

  // x0 hard-wired
  assign rdata_a_o = ((raddr_a_i == '0) || (int'(raddr_a_i) >= NUM_REGS)) ? '0 :
                     regs_q[raddr_a_i[AW-1:0]];
  assign rdata_b_o = ((raddr_b_i == '0) || (int'(raddr_b_i) >= NUM_REGS)) ? '0 :
                     regs_q[raddr_b_i[AW-1:0]];

endmodule

/* design/rv_isa_pkg.sv */
////////////////////
// RV32I base encodings only. No compressed or extension formats
////////////////////
package rv_isa_pkg;

  localparam int XLEN       = 32;  // Data and instruction width
  localparam int REG_ADDR_W = 5;   // Register index, also for RV32E
  localparam int OPCODE_W   = 7;
  localparam int FUNCT3_W   = 3;
  localparam int FUNCT7_W   = 7;

  typedef logic [XLEN-1:0]       word_t;
  typedef logic [REG_ADDR_W-1:0] reg_addr_t;

  // Major opcodes, instruction bits 6:0
  typedef enum logic [OPCODE_W-1:0] {
    OPC_LOAD    = 7'b0000011,
    OPC_MISCMEM = 7'b0001111,  // FENCE
    OPC_OPIMM   = 7'b0010011,
    OPC_AUIPC   = 7'b0010111,
    OPC_STORE   = 7'b0100011,
    OPC_OP      = 7'b0110011,
    OPC_LUI     = 7'b0110111,
    OPC_BRANCH  = 7'b1100011,
    OPC_JALR    = 7'b1100111,
    OPC_JAL     = 7'b1101111,
    OPC_SYSTEM  = 7'b1110011
  } opcode_t;

  // funct3 of OP and OP-IMM
  localparam logic [FUNCT3_W-1:0] FUNCT3_ADD  = 3'b000;  // Also SUB
  localparam logic [FUNCT3_W-1:0] FUNCT3_SLL  = 3'b001;
  localparam logic [FUNCT3_W-1:0] FUNCT3_SLT  = 3'b010;
  localparam logic [FUNCT3_W-1:0] FUNCT3_SLTU = 3'b011;
  localparam logic [FUNCT3_W-1:0] FUNCT3_XOR  = 3'b100;
  localparam logic [FUNCT3_W-1:0] FUNCT3_SR   = 3'b101;  // SRL and SRA
  localparam logic [FUNCT3_W-1:0] FUNCT3_OR   = 3'b110;
  localparam logic [FUNCT3_W-1:0] FUNCT3_AND  = 3'b111;

  localparam logic [FUNCT7_W-1:0] FUNCT7_BASE = 7'b0000000;
  localparam logic [FUNCT7_W-1:0] FUNCT7_ALT  = 7'b0100000;  // SUB and SRA

endpackage

/* design/writeback_stage.sv */
`timescale 1ns/100ps
////////////////////
// Register file write happens only on the retire handshake
////////////////////
module writeback_stage (
  input  logic                    clk_i,
  input  logic                    rstn_i,
  input  logic                    in_valid_i,
  output logic                    in_ready_o,
  input  core_uop_pkg::uop_kind_t in_kind_i,
  input  rv_isa_pkg::reg_addr_t   in_rd_i,
  input  logic                    in_we_i,
  input  rv_isa_pkg::word_t       in_data_i,
  input  rv_isa_pkg::word_t       in_store_data_i,
  input  core_uop_pkg::lsu_ctrl_t in_lsu_ctrl_i,
  output logic                    retire_valid_o,
  input  logic                    retire_ready_i,
  output core_uop_pkg::uop_kind_t retire_kind_o,
  output rv_isa_pkg::reg_addr_t   retire_rd_o,
  output logic                    retire_we_o,
  output rv_isa_pkg::word_t       retire_data_o,
  output rv_isa_pkg::word_t       retire_store_data_o,
  output core_uop_pkg::lsu_ctrl_t retire_lsu_ctrl_o,
  output logic                    rf_we_o,
  output rv_isa_pkg::reg_addr_t   rf_waddr_o,
  output rv_isa_pkg::word_t       rf_wdata_o,
  output logic                    wb_valid_o,
  output logic                    wb_we_o,
  output rv_isa_pkg::reg_addr_t   wb_rd_o,
  output rv_isa_pkg::word_t       wb_data_o
);
  import rv_isa_pkg::*;
  import core_uop_pkg::*;

  logic      valid_q;
  uop_kind_t kind_q;
  reg_addr_t rd_q;
  logic      we_q;
  word_t     data_q;     // Result or effective address
  word_t     sdata_q;
  lsu_ctrl_t lsu_q;

  assign in_ready_o = !valid_q || retire_ready_i;

  always_ff @(posedge clk_i) begin
    if (!rstn_i) begin
      valid_q <= 1'b0;
    end else if (in_ready_o) begin
      valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    if (in_valid_i && in_ready_o) begin
      kind_q  <= in_kind_i;
      rd_q    <= in_rd_i;
      we_q    <= in_we_i;
      data_q  <= in_data_i;
      sdata_q <= in_store_data_i;
      lsu_q   <= in_lsu_ctrl_i;
    end
  end

  ////////////////////
  // Retire port
  ////////////////////
  assign retire_valid_o      = valid_q;
  assign retire_kind_o       = kind_q;
  assign retire_rd_o         = rd_q;
  assign retire_we_o         = we_q;
  assign retire_data_o       = data_q;
  assign retire_store_data_o = sdata_q;
  assign retire_lsu_ctrl_o   = lsu_q;

  assign rf_we_o    = valid_q && retire_ready_i && we_q;  // Commit on handshake
  assign rf_waddr_o = rd_q;
  assign rf_wdata_o = data_q;

  // Forwarding source for execute
  assign wb_valid_o = valid_q;
  assign wb_we_o    = we_q;
  assign wb_rd_o    = rd_q;
  assign wb_data_o  = data_q;

  a_retire_stable: assert property (@(posedge clk_i) disable iff (!rstn_i)
    valid_q && !retire_ready_i |=> valid_q && $stable(kind_q) && $stable(rd_q) &&
      $stable(we_q) && $stable(data_q) && $stable(sdata_q) && $stable(lsu_q));

endmodule

/* project.f */
+incdir+bench
design/rv_isa_pkg.sv
design/core_uop_pkg.sv
design/decode_stage.sv
design/reg_file.sv
design/execute_stage.sv
design/writeback_stage.sv
design/int_core_top.sv
bench/tb_int_core.sv
